/* rtl/dma_sched_pkg.sv */
// ============================================================
// DMA descriptor scheduler shared definitions
// Widths, descriptor and engine layouts, state and event
// encodings, and the monitor packet builder
// ============================================================

package dma_sched_pkg;

    // ============================================================
    // Widths and fixed identifiers
    // ============================================================
    localparam int ADDR_W          = 64;
    localparam int BEAT_W          = 32;
    // 512-bit data beat, 64 bytes
    localparam int BEAT_BYTES_LOG2 = 6;
    localparam int DESC_W          = 256;
    localparam int MON_PKT_W       = 64;
    localparam int MON_PAYLOAD_W   = 38;

    localparam logic [7:0] MON_AGENT_ID      = 8'h40;
    localparam logic [3:0] MON_UNIT_ID       = 4'h1;
    localparam logic [5:0] MON_CHANNEL_ID    = 6'h0;
    localparam logic [1:0] MON_PROTOCOL_CORE = 2'b00;

    // ============================================================
    // Descriptor and engine layouts
    // ============================================================
    // Field order follows packet bits 194:0, upper bits reserved
    typedef struct packed {
        logic              last;
        logic              gen_irq;
        logic              valid;
        logic [31:0]       next_ptr;
        logic [BEAT_W-1:0] length;
        logic [ADDR_W-1:0] dst_addr;
        logic [ADDR_W-1:0] src_addr;
    } desc_t;

    // Completion report from one engine
    typedef struct packed {
        logic              strobe;
        logic [BEAT_W-1:0] beats_done;
        logic              error;
    } eng_done_t;

    // Request to one engine, beats is what is still left
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [BEAT_W-1:0] beats;
    } eng_req_t;

    // ============================================================
    // Encodings
    // ============================================================
    typedef enum logic [2:0] {
        CH_IDLE       = 3'd0,
        CH_FETCH_DESC = 3'd1,
        CH_XFER_DATA  = 3'd2,
        CH_COMPLETE   = 3'd3,
        CH_NEXT_DESC  = 3'd4,
        CH_ERROR      = 3'd5
    } chan_state_t;

    typedef enum logic [3:0] {
        EVT_DESC_START    = 4'h0,
        EVT_DESC_COMPLETE = 4'h1,
        EVT_IRQ           = 4'h2,
        EVT_ERROR         = 4'hF
    } mon_event_t;

    typedef enum logic [1:0] {
        PKT_COMPLETION = 2'd0,
        PKT_ERROR      = 2'd3
    } mon_pkt_type_t;

    // Agent, unit, channel, event, protocol, type, payload from MSB down
    function automatic logic [MON_PKT_W-1:0] build_mon_packet(
        input mon_pkt_type_t            pkt_type,
        input mon_event_t               evt,
        input logic [MON_PAYLOAD_W-1:0] payload
    );
        return {MON_AGENT_ID, MON_UNIT_ID, MON_CHANNEL_ID, evt,
                MON_PROTOCOL_CORE, pkt_type, payload};
    endfunction

endpackage

/* rtl/desc_intake.sv */
// ============================================================
// Descriptor intake
// Decodes the 256-bit descriptor packet and latches it on
// the valid/ready handshake
// ============================================================

`timescale 1ns/1ps

module desc_intake
    import dma_sched_pkg::*;
(
    input  logic              clk,
    input  logic              r_channel_reset_active,
    input  chan_state_t       state,
    input  logic              channel_enable,
    input  logic              descriptor_valid,
    input  logic [DESC_W-1:0] descriptor_packet,
    output logic              descriptor_ready,
    output logic              desc_take,
    output desc_t             desc
);

    desc_t r_desc;
    desc_t w_desc;

    // Low bits carry the fields, the rest is reserved
    assign w_desc = desc_t'(descriptor_packet[$bits(desc_t)-1:0]);

    // Ready in idle and while waiting for a chained descriptor
    assign descriptor_ready = (state == CH_IDLE) || (state == CH_NEXT_DESC);

    // First descriptor needs the channel enabled
    // Chained ones are taken regardless
    assign desc_take = descriptor_valid && descriptor_ready &&
                       ((state != CH_IDLE) || channel_enable);

    // Latch on take, stable from the next cycle on
    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_desc <= '0;
        end else if (desc_take) begin
            r_desc <= w_desc;
        end
    end

    assign desc = r_desc;

endmodule

/* rtl/channel_fsm.sv */
// ============================================================
// Channel state machine
// Sequences fetch, transfer, completion and chaining, holds
// sticky engine error flags and the status outputs
// ============================================================

`timescale 1ns/1ps

module channel_fsm
    import dma_sched_pkg::*;
(
    input  logic        clk,
    input  logic        r_channel_reset_active,
    input  logic        desc_take,
    input  desc_t       desc,
    input  logic        xfer_done,
    input  logic        wr_ready,
    input  logic        descriptor_error,
    input  logic        rd_err,
    input  logic        wr_err,
    output chan_state_t state,
    output logic [1:0]  err_flags,
    output logic        scheduler_idle,
    output logic        sched_error
);

    chan_state_t r_state;
    chan_state_t w_next_state;
    logic        r_rd_err_sticky;
    logic        r_wr_err_sticky;
    logic        w_any_err;

    assign w_any_err = descriptor_error || rd_err || wr_err;

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        w_next_state = r_state;
        // Errors win over every normal transition
        if (w_any_err && (r_state != CH_ERROR)) begin
            w_next_state = CH_ERROR;
        end else begin
            case (r_state)
                CH_IDLE: begin
                    if (desc_take) begin
                        w_next_state = CH_FETCH_DESC;
                    end
                end
                CH_FETCH_DESC: begin
                    // Valid bit of the latched descriptor decides
                    w_next_state = desc.valid ? CH_XFER_DATA : CH_ERROR;
                end
                CH_XFER_DATA: begin
                    // Both sides drained and write side settled
                    if (xfer_done && wr_ready) begin
                        w_next_state = CH_COMPLETE;
                    end
                end
                CH_COMPLETE: begin
                    // Chain on non-zero pointer unless marked last
                    if ((desc.next_ptr != 32'h0) && !desc.last) begin
                        w_next_state = CH_NEXT_DESC;
                    end else begin
                        w_next_state = CH_IDLE;
                    end
                end
                CH_NEXT_DESC: begin
                    if (desc_take) begin
                        w_next_state = CH_FETCH_DESC;
                    end
                end
                CH_ERROR: begin
                    // Terminal until reset
                    w_next_state = CH_ERROR;
                end
                default: begin
                    w_next_state = CH_ERROR;
                end
            endcase
        end
    end

    // ============================================================
    // State and sticky error registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_state         <= CH_IDLE;
            r_rd_err_sticky <= 1'b0;
            r_wr_err_sticky <= 1'b0;
        end else begin
            r_state <= w_next_state;
            if (rd_err) begin
                r_rd_err_sticky <= 1'b1;
            end
            if (wr_err) begin
                r_wr_err_sticky <= 1'b1;
            end
        end
    end

    assign state     = r_state;
    // Write flag above read flag
    assign err_flags = {r_wr_err_sticky, r_rd_err_sticky};

    // Status
    assign scheduler_idle = (r_state == CH_IDLE) || (r_state == CH_ERROR);
    assign sched_error    = (r_state == CH_ERROR);

endmodule

/* rtl/beat_tracker.sv */
// ============================================================
// Read and write beat tracking
// Per side remaining count and current address, advanced by
// the engine done strobes, and the engine requests
// ============================================================

`timescale 1ns/1ps

module beat_tracker
    import dma_sched_pkg::*;
(
    input  logic        clk,
    input  logic        r_channel_reset_active,
    input  chan_state_t state,
    input  desc_t       desc,
    input  eng_done_t   rd_done,
    input  eng_done_t   wr_done,
    output eng_req_t    rd_req,
    output eng_req_t    wr_req,
    output logic        xfer_done
);

    // Index 0 is the read side, index 1 the write side
    eng_done_t         w_done       [2];
    logic [ADDR_W-1:0] w_start_addr [2];
    logic [ADDR_W-1:0] r_addr       [2];
    logic [BEAT_W-1:0] r_beats      [2];
    logic              w_completing [2];
    logic              w_zero       [2];
    eng_req_t          w_req        [2];

    assign w_done[0]       = rd_done;
    assign w_done[1]       = wr_done;
    assign w_start_addr[0] = desc.src_addr;
    assign w_start_addr[1] = desc.dst_addr;

    // ============================================================
    // One counter and address per side
    // ============================================================
    for (genvar i = 0; i < 2; i++) begin : g_side
        always_ff @(posedge clk) begin
            if (r_channel_reset_active) begin
                r_beats[i] <= '0;
            end else if (state == CH_FETCH_DESC) begin
                // Load from the latched descriptor
                r_beats[i] <= desc.length;
                r_addr[i]  <= w_start_addr[i];
            end else if ((state == CH_XFER_DATA) && w_done[i].strobe) begin
                // Saturate at zero on an overshooting report
                if (r_beats[i] >= w_done[i].beats_done) begin
                    r_beats[i] <= r_beats[i] - w_done[i].beats_done;
                end else begin
                    r_beats[i] <= '0;
                end
                // 64 bytes per beat
                r_addr[i] <= r_addr[i] +
                             (ADDR_W'(w_done[i].beats_done) << BEAT_BYTES_LOG2);
            end
        end

        // Strobe that finishes the count this very cycle
        assign w_completing[i] = w_done[i].strobe &&
                                 (r_beats[i] <= w_done[i].beats_done);
        assign w_zero[i] = (r_beats[i] == '0);

        // Valid drops in the completing cycle so no extra burst is issued
        assign w_req[i].valid = (state == CH_XFER_DATA) && !w_zero[i] &&
                                !w_completing[i];
        assign w_req[i].addr  = r_addr[i];
        assign w_req[i].beats = r_beats[i];
    end

    assign rd_req    = w_req[0];
    assign wr_req    = w_req[1];
    assign xfer_done = w_zero[0] && w_zero[1];

endmodule

/* rtl/mon_event_gen.sv */
// ============================================================
// Monitor event generator
// Registers one 64-bit monitor packet per start, completion
// and error cycle of the channel
// ============================================================

`timescale 1ns/1ps

module mon_event_gen
    import dma_sched_pkg::*;
(
    input  logic                 clk,
    input  logic                 r_channel_reset_active,
    input  chan_state_t          state,
    input  desc_t                desc,
    input  logic [1:0]           err_flags,
    output logic                 mon_valid,
    output logic [MON_PKT_W-1:0] mon_packet
);

    logic                     r_mon_valid;
    logic [MON_PKT_W-1:0]     r_mon_packet;
    logic                     w_valid;
    logic [MON_PKT_W-1:0]     w_packet;
    logic [MON_PAYLOAD_W-1:0] w_len_payload;
    logic [MON_PAYLOAD_W-1:0] w_err_payload;

    // Length in the low bits
    assign w_len_payload = {{(MON_PAYLOAD_W - BEAT_W){1'b0}}, desc.length};
    // Write flag at bit 35, read flag at bit 34
    assign w_err_payload = {2'b00, err_flags, 34'h0};

    // Event select from the current state
    always_comb begin
        w_valid  = 1'b0;
        w_packet = '0;
        case (state)
            CH_FETCH_DESC: begin
                w_valid  = 1'b1;
                w_packet = build_mon_packet(PKT_COMPLETION, EVT_DESC_START, w_len_payload);
            end
            CH_COMPLETE: begin
                w_valid = 1'b1;
                if (desc.gen_irq) begin
                    w_packet = build_mon_packet(PKT_COMPLETION, EVT_IRQ, w_len_payload);
                end else begin
                    w_packet = build_mon_packet(PKT_COMPLETION, EVT_DESC_COMPLETE,
                                                w_len_payload);
                end
            end
            CH_ERROR: begin
                // Repeats every cycle while in error
                w_valid  = 1'b1;
                w_packet = build_mon_packet(PKT_ERROR, EVT_ERROR, w_err_payload);
            end
            default: begin
                w_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (r_channel_reset_active) begin
            r_mon_valid <= 1'b0;
        end else begin
            r_mon_valid <= w_valid;
        end
        r_mon_packet <= w_packet;
    end

    assign mon_valid  = r_mon_valid;
    assign mon_packet = r_mon_packet;

endmodule

/* rtl/dma_sched_top.sv */
// ============================================================
// DMA descriptor scheduler top level
// Descriptor intake, channel FSM, beat tracking and monitor
// packet generation for one memory-to-memory channel
// ============================================================

`timescale 1ns/1ps

module dma_sched_top
    import dma_sched_pkg::*;
(
    input  logic                 clk,
    input  logic                 r_channel_reset_active,
    input  logic                 channel_enable,
    input  logic                 descriptor_valid,
    input  logic [DESC_W-1:0]    descriptor_packet,
    input  logic                 descriptor_error,
    input  eng_done_t            rd_done,
    input  eng_done_t            wr_done,
    input  logic                 wr_ready,
    output logic                 descriptor_ready,
    output eng_req_t             rd_req,
    output eng_req_t             wr_req,
    output logic                 scheduler_idle,
    output logic                 sched_error,
    output logic                 mon_valid,
    output logic [MON_PKT_W-1:0] mon_packet
);

    chan_state_t state;
    desc_t       desc;
    logic        desc_take;
    logic [1:0]  err_flags;
    logic        xfer_done;

    // Input side
    desc_intake u_intake (
        .clk                    (clk),
        .r_channel_reset_active (r_channel_reset_active),
        .state                  (state),
        .channel_enable         (channel_enable),
        .descriptor_valid       (descriptor_valid),
        .descriptor_packet      (descriptor_packet),
        .descriptor_ready       (descriptor_ready),
        .desc_take              (desc_take),
        .desc                   (desc)
    );

    // Processing core, error bits split out of the done reports
    channel_fsm u_fsm (
        .clk                    (clk),
        .r_channel_reset_active (r_channel_reset_active),
        .desc_take              (desc_take),
        .desc                   (desc),
        .xfer_done              (xfer_done),
        .wr_ready               (wr_ready),
        .descriptor_error       (descriptor_error),
        .rd_err                 (rd_done.error),
        .wr_err                 (wr_done.error),
        .state                  (state),
        .err_flags              (err_flags),
        .scheduler_idle         (scheduler_idle),
        .sched_error            (sched_error)
    );

    beat_tracker u_tracker (
        .clk                    (clk),
        .r_channel_reset_active (r_channel_reset_active),
        .state                  (state),
        .desc                   (desc),
        .rd_done                (rd_done),
        .wr_done                (wr_done),
        .rd_req                 (rd_req),
        .wr_req                 (wr_req),
        .xfer_done              (xfer_done)
    );

    // Output side
    mon_event_gen u_mon (
        .clk                    (clk),
        .r_channel_reset_active (r_channel_reset_active),
        .state                  (state),
        .desc                   (desc),
        .err_flags              (err_flags),
        .mon_valid              (mon_valid),
        .mon_packet             (mon_packet)
    );

endmodule

/* test/sched_checker.sv */
// ============================================================
// DMA scheduler checker
// Cycle model of the channel driven by the observed stimulus,
// compared against the DUT outputs at every clock edge
// ============================================================

`timescale 1ns/1ps

module sched_checker
    import dma_sched_pkg::*;
(
    input  logic              clk,
    input  logic              r_channel_reset_active,
    input  logic              channel_enable,
    input  logic              descriptor_valid,
    input  logic [DESC_W-1:0] descriptor_packet,
    input  logic              descriptor_error,
    input  eng_done_t         rd_done,
    input  eng_done_t         wr_done,
    input  logic              wr_ready,
    input  logic              descriptor_ready,
    input  eng_req_t          rd_req,
    input  eng_req_t          wr_req,
    input  logic              scheduler_idle,
    input  logic              sched_error,
    input  logic              mon_valid,
    input  logic [63:0]       mon_packet,
    output int unsigned       check_count,
    output int unsigned       error_count,
    output int unsigned       desc_count
);

    chan_state_t       m_state;
    desc_t             m_desc;
    logic [BEAT_W-1:0] m_left [2];
    logic [ADDR_W-1:0] m_addr [2];
    logic              m_rd_flag;
    logic              m_wr_flag;
    logic              m_mon_valid;
    logic [63:0]       m_mon_pkt;
    // Index 0 read side, 1 write side
    eng_done_t         done_s [2];
    eng_req_t          req_s  [2];

    assign done_s[0] = rd_done;
    assign done_s[1] = wr_done;
    assign req_s[0]  = rd_req;
    assign req_s[1]  = wr_req;

    initial begin
        check_count = 0;
        error_count = 0;
        desc_count  = 0;
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // Agent 0x40, unit 1, channel 0, protocol 0
    function automatic logic [63:0] pack_monitor(input logic [1:0] typ, input logic [3:0] evt,
                                                 input logic [37:0] payload);
        logic [63:0] p;
        p[63:56] = 8'h40;
        p[55:52] = 4'h1;
        p[51:46] = 6'h0;
        p[45:42] = evt;
        p[41:40] = 2'b00;
        p[39:38] = typ;
        p[37:0]  = payload;
        return p;
    endfunction

    task automatic check_side(input string name, input int i);
        logic exp_valid;
        // Drops in the same cycle as the strobe that drains the count
        exp_valid = (m_state == CH_XFER_DATA) && (m_left[i] != 32'h0) &&
                    !(done_s[i].strobe && (done_s[i].beats_done >= m_left[i]));
        compare({name, " valid"}, 64'(exp_valid), 64'(req_s[i].valid));
        if (m_state == CH_XFER_DATA) begin
            compare({name, " addr"}, m_addr[i], req_s[i].addr);
            compare({name, " beats"}, 64'(m_left[i]), 64'(req_s[i].beats));
        end
    endtask

    task automatic check_outputs();
        logic exp_ready;
        exp_ready = (m_state == CH_IDLE) || (m_state == CH_NEXT_DESC);
        compare("descriptor ready", 64'(exp_ready), 64'(descriptor_ready));
        compare("scheduler idle", 64'((m_state == CH_IDLE) || (m_state == CH_ERROR)),
                64'(scheduler_idle));
        compare("sched error", 64'(m_state == CH_ERROR), 64'(sched_error));
        check_side("rd_req", 0);
        check_side("wr_req", 1);
        compare("monitor valid", 64'(m_mon_valid), 64'(mon_valid));
        if (m_mon_valid) begin
            compare("monitor packet", m_mon_pkt, mon_packet);
        end
    endtask

    // ============================================================
    // Model step for one clock edge
    // ============================================================
    task automatic step_model();
        logic        take;
        logic        any_err;
        logic        drained;
        chan_state_t nxt;
        take    = descriptor_valid &&
                  (((m_state == CH_IDLE) && channel_enable) || (m_state == CH_NEXT_DESC));
        any_err = descriptor_error || rd_done.error || wr_done.error;
        drained = (m_left[0] == 32'h0) && (m_left[1] == 32'h0);
        // Packet for this cycle's state appears one cycle later
        m_mon_valid = 1'b1;
        case (m_state)
            CH_FETCH_DESC: begin
                m_mon_pkt = pack_monitor(PKT_COMPLETION, EVT_DESC_START, 38'(m_desc.length));
            end
            CH_COMPLETE: begin
                m_mon_pkt = pack_monitor(PKT_COMPLETION,
                                         m_desc.gen_irq ? EVT_IRQ : EVT_DESC_COMPLETE,
                                         38'(m_desc.length));
            end
            CH_ERROR: begin
                m_mon_pkt = pack_monitor(PKT_ERROR, EVT_ERROR,
                                         {2'b00, m_wr_flag, m_rd_flag, 34'h0});
            end
            default: begin
                m_mon_valid = 1'b0;
            end
        endcase
        nxt = m_state;
        if (any_err && (m_state != CH_ERROR)) begin
            nxt = CH_ERROR;
        end else if (((m_state == CH_IDLE) || (m_state == CH_NEXT_DESC)) && take) begin
            nxt = CH_FETCH_DESC;
        end else if (m_state == CH_FETCH_DESC) begin
            nxt = m_desc.valid ? CH_XFER_DATA : CH_ERROR;
        end else if ((m_state == CH_XFER_DATA) && drained && wr_ready) begin
            nxt = CH_COMPLETE;
        end else if (m_state == CH_COMPLETE) begin
            // Chain unless the pointer is null or last is set
            nxt = ((m_desc.next_ptr != 32'h0) && !m_desc.last) ? CH_NEXT_DESC : CH_IDLE;
        end
        for (int i = 0; i < 2; i++) begin
            if (m_state == CH_FETCH_DESC) begin
                m_left[i] = m_desc.length;
                m_addr[i] = (i == 0) ? m_desc.src_addr : m_desc.dst_addr;
            end else if ((m_state == CH_XFER_DATA) && done_s[i].strobe) begin
                m_left[i] = (done_s[i].beats_done >= m_left[i]) ? 32'h0 :
                            m_left[i] - done_s[i].beats_done;
                m_addr[i] = m_addr[i] + 64'(done_s[i].beats_done) * 64'd64;
            end
        end
        if (take) begin
            m_desc.src_addr = descriptor_packet[63:0];
            m_desc.dst_addr = descriptor_packet[127:64];
            m_desc.length   = descriptor_packet[159:128];
            m_desc.next_ptr = descriptor_packet[191:160];
            m_desc.valid    = descriptor_packet[192];
            m_desc.gen_irq  = descriptor_packet[193];
            m_desc.last     = descriptor_packet[194];
            desc_count++;
        end
        m_rd_flag = m_rd_flag | rd_done.error;
        m_wr_flag = m_wr_flag | wr_done.error;
        m_state   = nxt;
    endtask

    always @(posedge clk) begin
        if (r_channel_reset_active) begin
            m_state     = CH_IDLE;
            m_rd_flag   = 1'b0;
            m_wr_flag   = 1'b0;
            m_mon_valid = 1'b0;
            m_left[0]   = 32'h0;
            m_left[1]   = 32'h0;
        end else begin
            check_outputs();
            step_model();
        end
    end

endmodule

/* test/tb_dma_sched.sv */
// ============================================================
// DMA descriptor scheduler testbench
// Random descriptors and engine responses from an xorshift
// source, with all comparing done in sched_checker
// ============================================================

`timescale 1ns/1ps

module tb_dma_sched
    import dma_sched_pkg::*;
();

    localparam int          NUM_DESC     = 40;
    localparam int          CYC_PER_DESC = 200;
    localparam int          MAX_CYCLES   = NUM_DESC * CYC_PER_DESC;
    localparam logic [31:0] SEED         = 32'd33;

    logic                 clk = 1'b0;
    logic                 r_channel_reset_active;
    logic                 channel_enable;
    logic                 descriptor_valid;
    logic [DESC_W-1:0]    descriptor_packet;
    logic                 descriptor_error;
    eng_done_t            rd_done;
    eng_done_t            wr_done;
    logic                 wr_ready;
    logic                 descriptor_ready;
    eng_req_t             rd_req;
    eng_req_t             wr_req;
    logic                 scheduler_idle;
    logic                 sched_error;
    logic                 mon_valid;
    logic [MON_PKT_W-1:0] mon_packet;

    // Engine model state and injected errors
    logic                 rd_stb;
    logic                 wr_stb;
    logic [BEAT_W-1:0]    rd_cnt;
    logic [BEAT_W-1:0]    wr_cnt;
    logic                 inj_rd_err;
    logic                 inj_wr_err;

    logic [31:0]          main_rng;
    logic [31:0]          eng_rng;
    int unsigned          cycles = 0;
    int unsigned          check_count;
    int unsigned          error_count;
    int unsigned          desc_count;

    assign rd_done = {rd_stb, rd_cnt, inj_rd_err};
    assign wr_done = {wr_stb, wr_cnt, inj_wr_err};

    always #2 clk = ~clk;

    dma_sched_top u_dut (.*);

    sched_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] v);
        main_rng = xorshift(main_rng);
        v = main_rng;
    endtask

    // Fields at their packet bit positions, reserved bits zero
    function automatic logic [DESC_W-1:0] make_descriptor(
        input logic [63:0] src,
        input logic [63:0] dst,
        input logic [31:0] len,
        input logic [31:0] nxt,
        input logic        vld,
        input logic        irq,
        input logic        last
    );
        logic [DESC_W-1:0] p;
        p = '0;
        p[63:0]    = src;
        p[127:64]  = dst;
        p[159:128] = len;
        p[191:160] = nxt;
        p[192]     = vld;
        p[193]     = irq;
        p[194]     = last;
        return p;
    endfunction

    task automatic apply_reset();
        r_channel_reset_active = 1'b1;
        repeat (5) @(negedge clk);
        r_channel_reset_active = 1'b0;
    endtask

    // One engine, never strobes two cycles in a row
    task automatic step_engine(input eng_req_t req, inout logic stb,
                               inout logic [BEAT_W-1:0] cnt);
        if (stb) begin
            stb = 1'b0;
        end else if (req.valid === 1'b1) begin
            eng_rng = xorshift(eng_rng);
            if (eng_rng[0]) begin
                stb = 1'b1;
                // Between 1 and the beats still shown
                cnt = 32'd1 + ((eng_rng >> 1) % req.beats);
            end
        end
    endtask

    always @(negedge clk) begin
        step_engine(rd_req, rd_stb, rd_cnt);
        step_engine(wr_req, wr_stb, wr_cnt);
        eng_rng  = xorshift(eng_rng);
        wr_ready = eng_rng[2] | eng_rng[3];
    end

    // ============================================================
    // One descriptor from presentation to idle, chain or error
    // ============================================================
    task automatic run_descriptor();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic        chained;
        int unsigned mode;
        int unsigned inj_at;
        int unsigned cyc;
        draw(a);
        draw(b);
        draw(c);
        draw(d);
        // Mode 0 invalid, 1 read error, 2 write error, 3 descriptor error
        mode    = a % 12;
        inj_at  = c % 3;
        chained = descriptor_ready && !scheduler_idle;
        descriptor_packet = make_descriptor({b, c}, {d, a}, {28'h0, a[7:4]} + 32'd1,
                                            b[0] ? 32'h0 : (b | 32'h10), mode != 0,
                                            a[8], b[1] & b[2]);
        descriptor_valid = 1'b1;
        if (chained) begin
            // Chained descriptor does not need the enable
            channel_enable = 1'b0;
        end else if (a[9]) begin
            // Disabled channel holds the descriptor off
            channel_enable = 1'b0;
            repeat (3) @(negedge clk);
            channel_enable = 1'b1;
        end else begin
            channel_enable = 1'b1;
        end
        @(negedge clk);
        while (descriptor_ready) begin
            @(negedge clk);
        end
        descriptor_valid = 1'b0;
        cyc = 0;
        while (!(descriptor_ready || scheduler_idle)) begin
            descriptor_error = (mode == 3) && (cyc == inj_at);
            inj_rd_err       = (mode == 1) && (cyc == inj_at);
            inj_wr_err       = (mode == 2) && (cyc == inj_at);
            @(negedge clk);
            cyc++;
        end
        descriptor_error = 1'b0;
        inj_rd_err       = 1'b0;
        inj_wr_err       = 1'b0;
        if (sched_error) begin
            // Let a few error packets repeat before clearing
            repeat (3) @(negedge clk);
            apply_reset();
        end
    endtask

    initial begin
        channel_enable    = 1'b0;
        descriptor_valid  = 1'b0;
        descriptor_packet = '0;
        descriptor_error  = 1'b0;
        wr_ready          = 1'b0;
        rd_stb            = 1'b0;
        wr_stb            = 1'b0;
        rd_cnt            = '0;
        wr_cnt            = '0;
        inj_rd_err        = 1'b0;
        inj_wr_err        = 1'b0;
        main_rng          = SEED;
        eng_rng           = xorshift(SEED);
        apply_reset();
        for (int i = 0; i < NUM_DESC; i++) begin
            run_descriptor();
        end
        repeat (4) @(negedge clk);
        $display("Checks: %0d  errors: %0d  descriptors taken: %0d",
                 check_count, error_count, desc_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Run limit from the number of descriptors
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

/* all.f */
rtl/dma_sched_pkg.sv
rtl/desc_intake.sv
rtl/channel_fsm.sv
rtl/beat_tracker.sv
rtl/mon_event_gen.sv
rtl/dma_sched_top.sv
test/sched_checker.sv
test/tb_dma_sched.sv

/* Makefile */
# Verilator build and run of the DMA descriptor scheduler testbench

SIM = obj_dir/sim_dma_sched

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_dma_sched -f all.f -Mdir obj_dir -o sim_dma_sched

# Pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf obj_dir
